/* verilog.f */
fpu_pkg.sv
fp_lane_ops.sv
fp_meta_unit.sv
vreg_bank.sv
apb_regs.sv
fpu_sequencer.sv
fpu_top.sv
fpu_checker.sv
fpu_tb.sv

/* Makefile */
# Verilator build and run of the FPU regression

VERILATOR ?= verilator
TOP ?= fpu_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* fpu_tb.sv */
`timescale 1ns/100ps

module fpu_tb import fpu_pkg::*; ();

	localparam logic [31:0] SEED = 32'hb08f1a58;
	localparam int N_WIN = 40;
	localparam int N_CMD = 60;
	localparam int N_MERGE = 40;
	localparam int N_SPECIAL = 60;
	localparam int N_CONC = 20;
	// Rough APB transfer count of the whole run, STATUS polls included
	localparam int N_XFERS = 16 + N_WIN + 16 + 13 * N_CMD + 15 * N_MERGE +
		11 * N_SPECIAL + 40 + 16 * N_CONC + 16;
	// Each transfer needs about 3 cycles, so 20 leaves a wide margin
	localparam int TIMEOUT_CYCLES = 20 * N_XFERS;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW/8-1:0] pstrb;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	int err_cnt;
	int chk_cnt;
	int errs_before;
	int cycles;

	// Operand kinds for the special value pairs: 0 +0, 1 -0, 2 qNaN, 3 sNaN, 5 random
	int pair_a [5] = '{2, 3, 0, 1, 2};
	int pair_b [5] = '{5, 5, 1, 0, 3};
	fop_e special_ops [4] = '{FMIN, FMAX, FLT, FEQ};

	fpu_top i_dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	fpu_checker i_chk (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.err_cnt(err_cnt),
		.chk_cnt(chk_cnt)
	);

	// ==========================================================================
	// Clock and run limit
	// ==========================================================================

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
		$display("Regression failed");
		$finish;
	end

	// ==========================================================================
	// Operand generation, biased toward special encodings
	// ==========================================================================

	function automatic int exp_width(input logic [1:0] p);
		return (p == 2'd0) ? 5 : (p == 2'd1) ? 8 : 11;
	endfunction

	function automatic int man_width(input logic [1:0] p);
		return (p == 2'd0) ? 10 : (p == 2'd1) ? 23 : 52;
	endfunction

	// Kind 0 +0, 1 -0, 2 qNaN, 3 sNaN, 4 infinity, anything else random bits
	function automatic logic [63:0] make_lane(input int ew, input int mw, input int kind);
		logic [63:0] sgn;
		logic [63:0] expf;
		logic [63:0] qbit;
		logic [63:0] rnd;
		logic [63:0] s;
		sgn = 64'd1 << (ew + mw);
		qbit = 64'd1 << (mw - 1);
		expf = (sgn - 64'd1) & ~((64'd1 << mw) - 64'd1);
		rnd = {$urandom, $urandom} & (sgn - 64'd1);
		s = ($urandom % 2 == 1) ? sgn : 64'd0;
		case (kind)
			0: return 64'd0;
			1: return sgn;
			2: return s | expf | qbit | (rnd & (qbit - 64'd1));
			// Payload forced nonzero so the lane stays a NaN
			3: return s | expf | (rnd & (qbit - 64'd1)) | 64'd1;
			4: return s | expf;
			default: return s | rnd;
		endcase
	endfunction

	function automatic logic [63:0] lane_fill(input logic [1:0] p, input int kind, input bit mix);
		logic [63:0] w;
		int lw;
		int k;
		lw = exp_width(p) + man_width(p) + 1;
		w = '0;
		for (int i = 0; i < 64 / lw; i++) begin
			k = kind;
			// Half of the random lanes get one of the special kinds
			if (mix)
				k = int'($urandom % 10);
			w = w | (make_lane(exp_width(p), man_width(p), k) << (i * lw));
		end
		return w;
	endfunction

	function automatic logic [31:0] make_cmd(input logic [2:0] op, input logic [1:0] p,
		input logic zf, input logic [7:0] m, input logic [2:0] sa, input logic [2:0] sb,
		input logic [2:0] st, input logic [2:0] sd);
		logic [31:0] c;
		c = '0;
		c[CMD_OP +: 3] = op;
		c[CMD_PRC +: 2] = p;
		c[CMD_Z] = zf;
		c[CMD_MASK +: 8] = m;
		c[CMD_SRCA +: 3] = sa;
		c[CMD_SRCB +: 3] = sb;
		c[CMD_SRCT +: 3] = st;
		c[CMD_DST +: 3] = sd;
		return c;
	endfunction

	// ==========================================================================
	// APB driver
	// ==========================================================================

	// Inputs change 1 ns after the edge, pready and prdata are taken at the falling edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		input logic [3:0] strb, output logic [31:0] rdata);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		pstrb = wr ? strb : 4'h0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		rdata = prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, strb, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_xfer(1'b0, addr, 32'h0, 4'h0, data);
	endtask

	task automatic write_reg(input logic [2:0] r, input logic [63:0] v);
		apb_write({2'b00, r, 3'b000}, v[31:0], 4'hf);
		apb_write({2'b00, r, 3'b100}, v[63:32], 4'hf);
	endtask

	task automatic read_reg(input logic [2:0] r);
		logic [31:0] d;
		apb_read({2'b00, r, 3'b000}, d);
		apb_read({2'b00, r, 3'b100}, d);
	endtask

	task automatic read_all_regs();
		for (int r = 0; r < NREG; r++)
			read_reg(3'(r));
	endtask

	task automatic issue_cmd(input logic [2:0] op, input logic [1:0] p, input logic zf,
		input logic [7:0] m, input logic [2:0] sa, input logic [2:0] sb,
		input logic [2:0] st, input logic [2:0] sd);
		apb_write(ADDR_CMD, make_cmd(op, p, zf, m, sa, sb, st, sd), 4'hf);
	endtask

	// Polls STATUS, the last read also carries the sticky flag to the checker
	task automatic wait_idle();
		logic [31:0] s;
		s = 32'h1;
		while (s[0])
			apb_read(ADDR_STATUS, s);
	endtask

	task automatic clear_sticky();
		apb_write(ADDR_STATUS, 32'h2, 4'hf);
	endtask

	task automatic report_test(input string name);
		$display("Test %-8s %s, %0d errors", name,
			(err_cnt == errs_before) ? "ok" : "FAILED", err_cnt - errs_before);
		errs_before = err_cnt;
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial begin
		logic [1:0] p;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [31:0] d;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pstrb = '0;
		reset = 1'b1;
		errs_before = 0;
		void'($urandom(SEED));
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		read_all_regs();
		report_test("reset");

		// Random halves with random strobes, then both halves of every register
		for (int i = 0; i < N_WIN; i++)
			apb_write({2'b00, 3'($urandom), 1'($urandom), 2'b00}, $urandom, 4'($urandom));
		read_all_regs();
		report_test("window");

		for (int i = 0; i < N_CMD; i++) begin
			p = 2'($urandom % 3);
			ra = 3'($urandom);
			rb = 3'($urandom);
			rd = 3'($urandom);
			write_reg(ra, lane_fill(p, 5, 1'b1));
			write_reg(rb, lane_fill(p, 5, 1'b1));
			issue_cmd(3'($urandom), p, 1'b0, 8'h00, ra, rb, rb, rd);
			wait_idle();
			read_reg(rd);
		end
		report_test("ops");

		// Target comes from its own register so the merge sees fresh bytes
		for (int i = 0; i < N_MERGE; i++) begin
			p = 2'($urandom % 3);
			ra = 3'($urandom);
			rb = 3'($urandom);
			rt = 3'($urandom);
			rd = 3'($urandom);
			write_reg(ra, lane_fill(p, 5, 1'b1));
			write_reg(rb, lane_fill(p, 5, 1'b1));
			write_reg(rt, {$urandom, $urandom});
			issue_cmd(3'($urandom), p, 1'($urandom), 8'($urandom), ra, rb, rt, rd);
			wait_idle();
			read_reg(rd);
		end
		report_test("merge");

		for (int q = 0; q < 3; q++) begin
			for (int k = 0; k < 5; k++) begin
				for (int j = 0; j < 4; j++) begin
					write_reg(3'd0, lane_fill(2'(q), pair_a[k], 1'b0));
					write_reg(3'd1, lane_fill(2'(q), pair_b[k], 1'b0));
					issue_cmd(special_ops[j], 2'(q), 1'b0, 8'h00, 3'd0, 3'd1, 3'd0, 3'd2);
					wait_idle();
					clear_sticky();
					read_reg(3'd2);
				end
			end
		end
		report_test("special");

		// Reserved precision, a second command while busy, then addresses past STATUS
		issue_cmd(3'($urandom), 2'd3, 1'b0, 8'h00, 3'd0, 3'd1, 3'd2, 3'd3);
		issue_cmd(FMAX, 2'd0, 1'b0, 8'h00, 3'd4, 3'd5, 3'd6, 3'd7);
		issue_cmd(FMIN, 2'd1, 1'b0, 8'h00, 3'd0, 3'd1, 3'd2, 3'd3);
		wait_idle();
		apb_write(8'h48, $urandom, 4'hf);
		apb_write(8'h80, $urandom, 4'hf);
		apb_read(8'h4c, d);
		apb_read(ADDR_CMD, d);
		read_all_regs();
		report_test("errors");

		// The command owns registers 0 to 3 while the host works on 4 to 7
		for (int i = 0; i < N_CONC; i++) begin
			p = 2'($urandom % 3);
			write_reg(3'd0, lane_fill(p, 5, 1'b1));
			write_reg(3'd1, lane_fill(p, 5, 1'b1));
			write_reg(3'd2, {$urandom, $urandom});
			issue_cmd(3'($urandom), p, 1'($urandom), 8'($urandom), 3'd0, 3'd1, 3'd2, 3'd3);
			for (int j = 0; j < 4; j++) begin
				rt = {1'b1, 2'($urandom)};
				if ($urandom % 2 == 1)
					apb_write({2'b00, rt, 1'($urandom), 2'b00}, $urandom, 4'($urandom));
				else
					apb_read({2'b00, rt, 1'($urandom), 2'b00}, d);
			end
			wait_idle();
			read_reg(3'd3);
		end
		read_all_regs();
		report_test("contend");

		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* fpu_checker.sv */
`timescale 1ns/100ps

module fpu_checker import fpu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [APB_DW-1:0] pwdata,
	input  logic [APB_DW/8-1:0] pstrb,
	input  logic [APB_DW-1:0] prdata,
	input  logic pready,
	input  logic pslverr,
	output int err_cnt,
	output int chk_cnt
);

	logic [63:0] shadow [NREG];
	logic [31:0] cmd_q;
	logic exp_sticky;
	// A command was accepted and no idle STATUS read has been seen since
	logic pending;
	logic in_win;
	logic is_cmd;
	logic is_stat;
	logic exp_err;

	// ==========================================================================
	// Reference model of one lane and of the whole vector operation
	// ==========================================================================

	function automatic logic [63:0] lane_model(input fop_e op, input logic [63:0] a_in,
		input logic [63:0] b_in, input int ew, input int mw, output logic inv);
		logic [63:0] sgn;
		logic [63:0] mag;
		logic [63:0] lmask;
		logic [63:0] frac;
		logic [63:0] expf;
		logic [63:0] qbit;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] res;
		logic an;
		logic bn;
		logic asn;
		logic bsn;
		logic both_zero;
		logic less;
		sgn = 64'd1 << (ew + mw);
		mag = sgn - 64'd1;
		lmask = mag | sgn;
		frac = (64'd1 << mw) - 64'd1;
		expf = mag & ~frac;
		qbit = 64'd1 << (mw - 1);
		a = a_in & lmask;
		b = b_in & lmask;
		an = ((a & expf) == expf) && ((a & frac) != 0);
		bn = ((b & expf) == expf) && ((b & frac) != 0);
		asn = an && ((a & qbit) == 0);
		bsn = bn && ((b & qbit) == 0);
		both_zero = ((a & mag) == 0) && ((b & mag) == 0);
		// Total order over numbers, minus zero below plus zero
		if ((a & sgn) != (b & sgn))
			less = (a & sgn) != 0;
		else if ((a & sgn) != 0)
			less = (b & mag) < (a & mag);
		else
			less = (a & mag) < (b & mag);
		inv = 1'b0;
		res = a;
		case (op)
			FMIN, FMAX: begin
				if (an && bn)
					res = expf | qbit;
				else if (an)
					res = b;
				else if (bn)
					res = a;
				else if (op == FMIN)
					res = less ? a : b;
				else
					res = less ? b : a;
				inv = asn || bsn;
			end
			FNEG: res = a ^ sgn;
			FABS: res = a & mag;
			FSGNJ: res = (a & mag) | (b & sgn);
			FSGNJN: res = (a & mag) | (~b & sgn);
			FLT: begin
				res = (!an && !bn && less && !both_zero) ? lmask : 64'd0;
				inv = an || bn;
			end
			FEQ: begin
				res = (!an && !bn && (a == b || both_zero)) ? lmask : 64'd0;
				inv = asn || bsn;
			end
		endcase
		return res & lmask;
	endfunction

	function automatic logic [63:0] vec_model(input logic [31:0] c, input logic [63:0] ra,
		input logic [63:0] rb, input logic [63:0] rt, output logic inv);
		int ew;
		int mw;
		int lw;
		logic [63:0] res;
		logic [63:0] lane;
		logic [63:0] merged;
		logic li;
		logic [7:0] m;
		case (c[CMD_PRC +: 2])
			2'd0: begin
				ew = 5;
				mw = 10;
			end
			2'd1: begin
				ew = 8;
				mw = 23;
			end
			default: begin
				ew = 11;
				mw = 52;
			end
		endcase
		lw = ew + mw + 1;
		res = '0;
		inv = 1'b0;
		for (int i = 0; i < 64 / lw; i++) begin
			lane = lane_model(fop_e'(c[CMD_OP +: 3]), ra >> (i * lw), rb >> (i * lw), ew, mw, li);
			res = res | (lane << (i * lw));
			inv = inv | li;
		end
		// Masked bytes come from the target, or become zero with z
		m = c[CMD_MASK +: 8];
		for (int k = 0; k < 8; k++)
			merged[k*8 +: 8] = m[k] ? (c[CMD_Z] ? 8'h00 : rt[k*8 +: 8]) : res[k*8 +: 8];
		return merged;
	endfunction

	// ==========================================================================
	// Comparison and model update on every completed transfer
	// ==========================================================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			$display("Mismatch %s at addr 0x%02h: got 0x%08h, expected 0x%08h",
				name, paddr, got, exp);
			err_cnt++;
		end
	endtask

	task automatic apply_write();
		logic [2:0] r;
		int half;
		logic [63:0] res;
		logic inv;
		r = paddr[5:3];
		half = paddr[2] ? 32 : 0;
		if (in_win) begin
			for (int k = 0; k < 4; k++) begin
				if (pstrb[k])
					shadow[r][half + k*8 +: 8] = pwdata[k*8 +: 8];
			end
		end else if (is_cmd) begin
			// Operands are taken now, the host keeps away from them until idle
			res = vec_model(pwdata, shadow[pwdata[CMD_SRCA +: 3]],
				shadow[pwdata[CMD_SRCB +: 3]], shadow[pwdata[CMD_SRCT +: 3]], inv);
			shadow[pwdata[CMD_DST +: 3]] = res;
			exp_sticky = exp_sticky | inv;
			pending = 1'b1;
			cmd_q = pwdata;
		end else if (pwdata[1]) begin
			exp_sticky = 1'b0;
		end
	endtask

	task automatic check_read();
		logic [2:0] r;
		r = paddr[5:3];
		if (in_win) begin
			check_value("prdata", prdata, paddr[2] ? shadow[r][63:32] : shadow[r][31:0]);
		end else if (is_cmd) begin
			check_value("prdata", prdata, cmd_q);
		end else if (prdata[0]) begin
			if (!pending) begin
				$display("STATUS at %0t reports busy although no command was started", $time);
				err_cnt++;
			end
		end else begin
			// Idle means the last command wrote back and raised its flag
			pending = 1'b0;
			check_value("status_invalid", {31'd0, prdata[1]}, {31'd0, exp_sticky});
		end
	endtask

	// Outputs are stable mid-cycle, the transfer completes on the next rising edge
	always @(negedge clk) begin
		if (reset) begin
			for (int r = 0; r < NREG; r++)
				shadow[r] = '0;
			cmd_q = '0;
			exp_sticky = 1'b0;
			pending = 1'b0;
			err_cnt = 0;
			chk_cnt = 0;
		end else if (psel) begin
			in_win = paddr < ADDR_CMD;
			is_cmd = paddr == ADDR_CMD;
			is_stat = paddr == ADDR_STATUS;
			// Setup never completes, and only window accesses may stretch the access phase
			if (!penable)
				check_value("pready", {31'd0, pready}, 32'd0);
			else if (!in_win)
				check_value("pready", {31'd0, pready}, 32'd1);
			if (penable && pready) begin
				exp_err = !(in_win || is_cmd || is_stat) ||
					(is_cmd && pwrite && (pending || pwdata[CMD_PRC +: 2] == 2'd3));
				check_value("pslverr", {31'd0, pslverr}, {31'd0, exp_err});
				if (!exp_err && pwrite)
					apply_write();
				else if (!exp_err)
					check_read();
			end
		end
	end

endmodule

/* fpu_top.sv */
`timescale 1ns/100ps

module fpu_top import fpu_pkg::*; #(
	parameter int WID = fpu_pkg::WID
) (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [APB_DW-1:0] pwdata,
	input  logic [APB_DW/8-1:0] pstrb,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// Host side of the bank
	logic h_req;
	logic h_we;
	logic [REG_AW-1:0] h_addr;
	logic [WID-1:0] h_wdata;
	logic [WID/8-1:0] h_be;
	logic h_gnt;
	logic [WID-1:0] h_rdata;
	// Sequencer side of the bank
	logic s_req;
	logic s_we;
	logic [REG_AW-1:0] s_addr;
	logic [WID-1:0] s_wdata;
	logic [WID/8-1:0] s_be;
	logic s_gnt;
	logic [WID-1:0] s_rdata;
	// Command hand-off and meta unit hookup
	logic start;
	logic [APB_DW-1:0] cmd;
	logic busy;
	logic launch;
	fop_e op;
	prc_e prc;
	logic z;
	logic [WID/8-1:0] mask;
	logic [WID-1:0] a;
	logic [WID-1:0] b;
	logic [WID-1:0] t;
	logic [WID-1:0] o;
	logic done;
	logic invalid;

	apb_regs #(.WID(WID)) i_regs (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.h_req(h_req),
		.h_we(h_we),
		.h_addr(h_addr),
		.h_wdata(h_wdata),
		.h_be(h_be),
		.h_gnt(h_gnt),
		.h_rdata(h_rdata),
		.start(start),
		.cmd(cmd),
		.busy(busy),
		.invalid(invalid)
	);

	fpu_sequencer #(.WID(WID)) i_seq (
		.clk(clk),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.busy(busy),
		.s_req(s_req),
		.s_we(s_we),
		.s_addr(s_addr),
		.s_wdata(s_wdata),
		.s_be(s_be),
		.s_gnt(s_gnt),
		.s_rdata(s_rdata),
		.launch(launch),
		.op(op),
		.prc(prc),
		.z(z),
		.mask(mask),
		.a(a),
		.b(b),
		.t(t),
		.o(o),
		.done(done)
	);

	vreg_bank #(.WID(WID), .NREG(NREG)) i_bank (
		.clk(clk),
		.reset(reset),
		.h_req(h_req),
		.h_we(h_we),
		.h_addr(h_addr),
		.h_wdata(h_wdata),
		.h_be(h_be),
		.h_gnt(h_gnt),
		.h_rdata(h_rdata),
		.s_req(s_req),
		.s_we(s_we),
		.s_addr(s_addr),
		.s_wdata(s_wdata),
		.s_be(s_be),
		.s_gnt(s_gnt),
		.s_rdata(s_rdata)
	);

	fp_meta_unit #(.WID(WID)) i_meta (
		.clk(clk),
		.reset(reset),
		.launch(launch),
		.op(op),
		.prc(prc),
		.z(z),
		.mask(mask),
		.a(a),
		.b(b),
		.t(t),
		.o(o),
		.done(done),
		.invalid(invalid)
	);

endmodule

/* fpu_sequencer.sv */
`timescale 1ns/100ps

module fpu_sequencer import fpu_pkg::*; #(
	parameter int WID = fpu_pkg::WID
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [APB_DW-1:0] cmd,
	output logic busy,
	output logic s_req,
	output logic s_we,
	output logic [REG_AW-1:0] s_addr,
	output logic [WID-1:0] s_wdata,
	output logic [WID/8-1:0] s_be,
	input  logic s_gnt,
	input  logic [WID-1:0] s_rdata,
	output logic launch,
	output fop_e op,
	output prc_e prc,
	output logic z,
	output logic [WID/8-1:0] mask,
	output logic [WID-1:0] a,
	output logic [WID-1:0] b,
	output logic [WID-1:0] t,
	input  logic [WID-1:0] o,
	input  logic done
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_RD_A = 3'd1;
	localparam logic [2:0] ST_RD_B = 3'd2;
	localparam logic [2:0] ST_RD_T = 3'd3;
	localparam logic [2:0] ST_COMP = 3'd4;
	localparam logic [2:0] ST_WR = 3'd5;

	logic [2:0] state;
	logic [APB_DW-1:0] cmd_q;
	logic [WID-1:0] a_q;
	logic [WID-1:0] b_q;
	// Bank read data belongs to the previous state's operand
	logic rd_vld;
	// Meta unit result is ready and waits for the write grant
	logic res_vld;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			rd_vld <= 1'b0;
			res_vld <= 1'b0;
		end else begin
			rd_vld <= s_gnt && !s_we;
			case (state)
				ST_IDLE: if (start) state <= ST_RD_A;
				ST_RD_A: if (s_gnt) state <= ST_RD_B;
				ST_RD_B: if (s_gnt) state <= ST_RD_T;
				ST_RD_T: if (s_gnt) state <= ST_COMP;
				ST_COMP: state <= ST_WR;
				ST_WR: if (s_gnt) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
			if (s_gnt && s_we)
				res_vld <= 1'b0;
			else if (done)
				res_vld <= 1'b1;
		end
	end

	// Operand a arrives in the first read b cycle, b in the first read t cycle
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start)
			cmd_q <= cmd;
		if (rd_vld && state == ST_RD_B)
			a_q <= s_rdata;
		if (rd_vld && state == ST_RD_T)
			b_q <= s_rdata;
	end

	always_comb begin
		case (state)
			ST_RD_A: s_addr = cmd_q[CMD_SRCA +: REG_AW];
			ST_RD_B: s_addr = cmd_q[CMD_SRCB +: REG_AW];
			ST_RD_T: s_addr = cmd_q[CMD_SRCT +: REG_AW];
			default: s_addr = cmd_q[CMD_DST +: REG_AW];
		endcase
	end

	assign s_req = (state inside {ST_RD_A, ST_RD_B, ST_RD_T}) ||
		(state == ST_WR && (done || res_vld));
	assign s_we = state == ST_WR;
	assign s_wdata = o;
	assign s_be = '1;
	assign busy = state != ST_IDLE;

	// The target word is consumed straight from the bank in the compute cycle
	assign launch = state == ST_COMP;
	assign a = a_q;
	assign b = b_q;
	assign t = s_rdata;
	assign op = fop_e'(cmd_q[CMD_OP +: 3]);
	assign prc = prc_e'(cmd_q[CMD_PRC +: 2]);
	assign z = cmd_q[CMD_Z];
	assign mask = cmd_q[CMD_MASK +: WID/8];

endmodule

/* apb_regs.sv */
`timescale 1ns/100ps

module apb_regs import fpu_pkg::*; #(
	parameter int WID = fpu_pkg::WID
) (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [APB_DW-1:0] pwdata,
	input  logic [APB_DW/8-1:0] pstrb,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic h_req,
	output logic h_we,
	output logic [REG_AW-1:0] h_addr,
	output logic [WID-1:0] h_wdata,
	output logic [WID/8-1:0] h_be,
	input  logic h_gnt,
	input  logic [WID-1:0] h_rdata,
	output logic start,
	output logic [APB_DW-1:0] cmd,
	input  logic busy,
	input  logic invalid
);

	logic access;
	logic in_win;
	logic is_cmd;
	logic is_stat;
	logic bad_addr;
	logic cmd_bad;
	logic cmd_wr;
	// Read was granted, bank data is valid in this cycle
	logic rd_wait;
	logic sticky;

	assign access = psel && penable;
	assign in_win = paddr < ADDR_CMD;
	assign is_cmd = paddr == ADDR_CMD;
	assign is_stat = paddr == ADDR_STATUS;
	assign bad_addr = !(in_win || is_cmd || is_stat);

	// ==========================================================================
	// Register window, 32-bit halves mapped onto 64-bit byte strobes
	// ==========================================================================

	assign h_req = access && in_win && !rd_wait;
	assign h_we = pwrite;
	assign h_addr = paddr[REG_AW+2:3];
	assign h_wdata = {(WID/APB_DW){pwdata}};
	assign h_be = paddr[2] ? {pstrb, {(APB_DW/8){1'b0}}} : {{(APB_DW/8){1'b0}}, pstrb};

	always_ff @(posedge clk) begin
		if (reset)
			rd_wait <= 1'b0;
		else if (rd_wait)
			rd_wait <= 1'b0;
		else if (h_gnt && !pwrite)
			rd_wait <= 1'b1;
	end

	// A command is refused while one runs or when it asks for prc 3
	assign cmd_bad = busy || (prc_e'(pwdata[CMD_PRC +: 2]) == PRC_RSV);
	assign cmd_wr = access && is_cmd && pwrite && !cmd_bad;

	// Window writes finish on the grant, reads one cycle later
	always_comb begin
		pready = 1'b0;
		pslverr = 1'b0;
		if (access) begin
			if (in_win) begin
				pready = pwrite ? h_gnt : rd_wait;
			end else begin
				pready = 1'b1;
				pslverr = bad_addr || (is_cmd && pwrite && cmd_bad);
			end
		end
	end

	always_comb begin
		prdata = '0;
		if (in_win)
			prdata = paddr[2] ? h_rdata[WID-1 -: APB_DW] : h_rdata[APB_DW-1:0];
		else if (is_cmd)
			prdata = cmd;
		else if (is_stat)
			prdata = {{(APB_DW-2){1'b0}}, sticky, busy};
	end

	// Start fires the cycle after the CMD write, together with the new word
	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			cmd <= '0;
			sticky <= 1'b0;
		end else begin
			start <= cmd_wr;
			if (cmd_wr)
				cmd <= pwdata;
			// A new exception beats a clear in the same cycle
			if (invalid)
				sticky <= 1'b1;
			else if (access && is_stat && pwrite && pwdata[1])
				sticky <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (reset) pready |-> psel && penable)
		else $error("apb_regs: pready outside an access phase");

endmodule

/* vreg_bank.sv */
`timescale 1ns/100ps

module vreg_bank import fpu_pkg::*; #(
	parameter int WID = fpu_pkg::WID,
	parameter int NREG = fpu_pkg::NREG
) (
	input  logic clk,
	input  logic reset,
	input  logic h_req,
	input  logic h_we,
	input  logic [REG_AW-1:0] h_addr,
	input  logic [WID-1:0] h_wdata,
	input  logic [WID/8-1:0] h_be,
	output logic h_gnt,
	output logic [WID-1:0] h_rdata,
	input  logic s_req,
	input  logic s_we,
	input  logic [REG_AW-1:0] s_addr,
	input  logic [WID-1:0] s_wdata,
	input  logic [WID/8-1:0] s_be,
	output logic s_gnt,
	output logic [WID-1:0] s_rdata
);

	logic [WID-1:0] mem [NREG];
	// Set when the sequencer wins the next collision
	logic prio;
	logic wr_en;
	logic rd_en;
	logic [REG_AW-1:0] addr;
	logic [WID-1:0] wdata;
	logic [WID/8-1:0] be;
	logic [WID-1:0] rd_q;

	// ==========================================================================
	// Round-robin arbitration for the single port
	// ==========================================================================

	assign h_gnt = h_req && (!s_req || !prio);
	assign s_gnt = s_req && (!h_req || prio);

	// Priority flips on every collision so neither side can starve
	always_ff @(posedge clk) begin
		if (reset)
			prio <= 1'b0;
		else if (h_req && s_req)
			prio <= !prio;
	end

	// The granted side steers the port
	assign addr = s_gnt ? s_addr : h_addr;
	assign wdata = s_gnt ? s_wdata : h_wdata;
	assign be = s_gnt ? s_be : h_be;
	assign wr_en = (h_gnt && h_we) || (s_gnt && s_we);
	assign rd_en = (h_gnt && !h_we) || (s_gnt && !s_we);

	// ==========================================================================
	// Byte-writable storage, all registers read as zero after reset
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < NREG; r++)
				mem[r] <= '0;
		end else if (wr_en) begin
			for (int k = 0; k < WID/8; k++) begin
				if (be[k])
					mem[addr][k*8 +: 8] <= wdata[k*8 +: 8];
			end
		end
	end

	// Read data shows up the cycle after the grant, each side knows its own turn
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_q <= mem[addr];
	end

	assign h_rdata = rd_q;
	assign s_rdata = rd_q;

	assert property (@(posedge clk) disable iff (reset) !(h_gnt && s_gnt))
		else $error("vreg_bank: both grants high");

endmodule

/* fp_meta_unit.sv */
`timescale 1ns/100ps

module fp_meta_unit import fpu_pkg::*; #(
	parameter int WID = fpu_pkg::WID
) (
	input  logic clk,
	input  logic reset,
	input  logic launch,
	input  fop_e op,
	input  prc_e prc,
	input  logic z,
	input  logic [WID/8-1:0] mask,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	input  logic [WID-1:0] t,
	output logic [WID-1:0] o,
	output logic done,
	output logic invalid
);

	lane_word_u ua;
	lane_word_u ub;
	lane_word_u res_h;
	lane_word_u res_s;
	lane_word_u res_d;
	lane_word_u sel;
	logic [WID/16-1:0] inv_h;
	logic [WID/32-1:0] inv_s;
	logic [WID/64-1:0] inv_d;
	logic inv_sel;
	logic [WID-1:0] merged;

	assign ua = a;
	assign ub = b;

	// ==========================================================================
	// Lane arrays, one per precision, all fed from the same operand words
	// ==========================================================================

	for (genvar g = 0; g < WID/16; g++) begin : g_half
		fp_lane_ops #(.EXP_W(H_EXP), .MAN_W(H_MAN)) i_lane (
			.op(op),
			.a(ua.h[g]),
			.b(ub.h[g]),
			.o(res_h.h[g]),
			.invalid(inv_h[g])
		);
	end

	for (genvar g = 0; g < WID/32; g++) begin : g_single
		fp_lane_ops #(.EXP_W(S_EXP), .MAN_W(S_MAN)) i_lane (
			.op(op),
			.a(ua.s[g]),
			.b(ub.s[g]),
			.o(res_s.s[g]),
			.invalid(inv_s[g])
		);
	end

	for (genvar g = 0; g < WID/64; g++) begin : g_double
		fp_lane_ops #(.EXP_W(D_EXP), .MAN_W(D_MAN)) i_lane (
			.op(op),
			.a(ua.d),
			.b(ub.d),
			.o(res_d.d),
			.invalid(inv_d[g])
		);
	end

	// Only the lanes of the chosen precision contribute to the flag
	always_comb begin
		case (prc)
			PRC_H: begin
				sel = res_h;
				inv_sel = |inv_h;
			end
			PRC_S: begin
				sel = res_s;
				inv_sel = |inv_s;
			end
			PRC_D: begin
				sel = res_d;
				inv_sel = |inv_d;
			end
			default: begin
				sel = '0;
				inv_sel = 1'b0;
			end
		endcase
	end

	// A set mask bit keeps the target byte, or clears it when z is set
	always_comb begin
		for (int m = 0; m < WID/8; m++) begin
			if (mask[m])
				merged[m*8 +: 8] = z ? 8'h00 : t[m*8 +: 8];
			else
				merged[m*8 +: 8] = sel.d[m*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
			invalid <= 1'b0;
		end else begin
			done <= launch;
			invalid <= launch && inv_sel;
		end
	end

	// Result holds until the next launch so the write can wait for the bank
	always_ff @(posedge clk) begin
		if (launch)
			o <= merged;
	end

	// The register block refuses prc 3, so it must never reach the lanes
	assert property (@(posedge clk) disable iff (reset) launch |-> prc != PRC_RSV)
		else $error("fp_meta_unit: launch with reserved precision");

endmodule

/* fp_lane_ops.sv */
`timescale 1ns/100ps

module fp_lane_ops import fpu_pkg::*; #(
	parameter int EXP_W = 11,
	parameter int MAN_W = 52
) (
	input  fop_e op,
	input  logic [EXP_W+MAN_W:0] a,
	input  logic [EXP_W+MAN_W:0] b,
	output logic [EXP_W+MAN_W:0] o,
	output logic invalid
);

	localparam int LW = EXP_W + MAN_W + 1;

	logic sa;
	logic sb;
	logic a_nan;
	logic b_nan;
	logic a_snan;
	logic b_snan;
	logic a_zero;
	logic b_zero;
	logic any_nan;
	logic lt;
	logic [LW-1:0] qnan;

	assign sa = a[LW-1];
	assign sb = b[LW-1];

	// A NaN has an all-ones exponent and a nonzero fraction
	assign a_nan = (&a[LW-2:MAN_W]) && (|a[MAN_W-1:0]);
	assign b_nan = (&b[LW-2:MAN_W]) && (|b[MAN_W-1:0]);
	// The quiet bit is the top fraction bit, clear means signaling
	assign a_snan = a_nan && !a[MAN_W-1];
	assign b_snan = b_nan && !b[MAN_W-1];
	assign a_zero = ~|a[LW-2:0];
	assign b_zero = ~|b[LW-2:0];
	assign any_nan = a_nan || b_nan;

	// Canonical quiet NaN is positive with only the quiet bit set
	assign qnan = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}};

	// Sign-magnitude order where minus zero sits below plus zero
	// NaN operands are filtered out before this result is used
	always_comb begin
		if (sa != sb)
			lt = sa;
		else if (sa)
			lt = b[LW-2:0] < a[LW-2:0];
		else
			lt = a[LW-2:0] < b[LW-2:0];
	end

	always_comb begin
		o = a;
		invalid = 1'b0;
		case (op)
			FMIN, FMAX: begin
				// A single NaN loses to the number, two NaNs give the canonical one
				if (a_nan && b_nan)
					o = qnan;
				else if (a_nan)
					o = b;
				else if (b_nan)
					o = a;
				else if ((op == FMIN) == lt)
					o = a;
				else
					o = b;
				invalid = a_snan || b_snan;
			end
			FNEG: o = {~sa, a[LW-2:0]};
			FABS: o = {1'b0, a[LW-2:0]};
			FSGNJ: o = {sb, a[LW-2:0]};
			FSGNJN: o = {~sb, a[LW-2:0]};
			FLT: begin
				// Both zeros compare equal, so neither is less than the other
				o = {LW{lt && !any_nan && !(a_zero && b_zero)}};
				invalid = any_nan;
			end
			FEQ: begin
				o = {LW{!any_nan && ((a == b) || (a_zero && b_zero))}};
				invalid = a_snan || b_snan;
			end
		endcase
		// Sign operations only move bits and never raise an exception
		if (op inside {FNEG, FABS, FSGNJ, FSGNJN})
			assert (!invalid)
				else $error("fp_lane_ops: invalid raised by a sign operation");
	end

endmodule

/* fpu_pkg.sv */
package fpu_pkg;

	// ==========================================================================
	// Geometry of the datapath, the register bank and the APB port
	// ==========================================================================

	// Default datapath word width, passed down from the top level
	localparam int WID = 64;
	localparam int NREG = 8;
	localparam int REG_AW = 3;

	// APB carries 32-bit data with byte addresses below 0x100
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// Exponent and fraction widths of the three lane formats
	localparam int H_EXP = 5;
	localparam int H_MAN = 10;
	localparam int S_EXP = 8;
	localparam int S_MAN = 23;
	localparam int D_EXP = 11;
	localparam int D_MAN = 52;

	// Precision code, 3 is reserved and refused by the register block
	typedef enum logic [1:0] {
		PRC_H = 2'd0,
		PRC_S = 2'd1,
		PRC_D = 2'd2,
		PRC_RSV = 2'd3
	} prc_e;

	// Lane operations, SGNJ takes the magnitude of a and the sign of b
	typedef enum logic [2:0] {
		FMIN = 3'd0,
		FMAX = 3'd1,
		FNEG = 3'd2,
		FABS = 3'd3,
		FSGNJ = 3'd4,
		FSGNJN = 3'd5,
		FLT = 3'd6,
		FEQ = 3'd7
	} fop_e;

	// One 64-bit word seen as four halves, two singles or one double
	typedef union packed {
		logic [3:0][15:0] h;
		logic [1:0][31:0] s;
		logic [63:0] d;
	} lane_word_u;

	// Low bit of each field in the command word
	localparam int CMD_OP = 0;
	localparam int CMD_PRC = 3;
	localparam int CMD_Z = 5;
	localparam int CMD_MASK = 6;
	localparam int CMD_SRCA = 14;
	localparam int CMD_SRCB = 17;
	localparam int CMD_SRCT = 20;
	localparam int CMD_DST = 23;

	// Everything below the command register is the vector register window
	localparam logic [APB_AW-1:0] ADDR_CMD = 8'h40;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h44;

endpackage
